// ==== loopback_msg.f ====
+incdir+.
loopback_msg_pkg.sv
axis_msg_if.sv
header_remover.sv
axis_fifo.sv
loopback_msg_fifo.sv
loopback_msg_assert.sv
loopback_msg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module loopback_msg_tb \
    -f loopback_msg.f \
    -o sim_loopback_msg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_loopback_msg)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== loopback_msg_tb.sv ====
`timescale 1ns/1ns
`include "loopback_msg_macros.svh"

module loopback_msg_tb;

    localparam logic [31:0] SEED      = 32'h29cb711e;
    localparam int          MAX_BEATS = 512; // Per port over both phases

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]    data;
        logic [`STRB_WIDTH-1:0]    keep;
        logic                      last;
        loopback_msg_pkg::id_tag_t dest;
    } beat_t;

    logic                                 clk;
    logic                                 rst;
    logic [`PORT_COUNT*`DATA_WIDTH-1:0]   s_axis_tdata;
    logic [`PORT_COUNT*`STRB_WIDTH-1:0]   s_axis_tkeep;
    logic [`PORT_COUNT-1:0]               s_axis_tvalid;
    logic [`PORT_COUNT-1:0]               s_axis_tlast;
    logic [`PORT_COUNT*`ID_TAG_WIDTH-1:0] s_axis_tuser;
    logic [`PORT_COUNT-1:0]               s_axis_tready;
    logic [`PORT_COUNT*`DATA_WIDTH-1:0]   m_axis_tdata;
    logic [`PORT_COUNT*`STRB_WIDTH-1:0]   m_axis_tkeep;
    logic [`PORT_COUNT-1:0]               m_axis_tvalid;
    logic [`PORT_COUNT-1:0]               m_axis_tlast;
    logic [`PORT_COUNT*`ID_TAG_WIDTH-1:0] m_axis_tdest;
    logic [`PORT_COUNT*`PORT_WIDTH-1:0]   m_axis_tuser;
    logic [`PORT_COUNT-1:0]               m_axis_tready;

    logic [31:0] lfsr;
    beat_t       send_mem [`PORT_COUNT][MAX_BEATS]; // Beats as driven with the header included
    beat_t       exp_mem  [`PORT_COUNT][MAX_BEATS]; // Beats the outputs must deliver
    int          send_len [`PORT_COUNT];
    int          send_pos [`PORT_COUNT];
    int          send_end [`PORT_COUNT];
    int          exp_wr   [`PORT_COUNT];
    int          exp_rd   [`PORT_COUNT];
    int          exp_end  [`PORT_COUNT];
    int          phase1_send [`PORT_COUNT];
    int          phase1_exp  [`PORT_COUNT];
    bit          stall_seen  [`PORT_COUNT];
    int          check_errors;
    int          flow_errors;
    int          beats_checked;
    int          watch_cycles;

    loopback_msg_fifo u_dut (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdest  (m_axis_tdest),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Payload beat as it should leave the port with the tag of its frame header
    function automatic beat_t expected_beat(input logic [63:0] header, input beat_t payload);
        beat_t b;
        b      = payload;
        b.dest = header[`ID_TAG_WIDTH-1:0];
        return b;
    endfunction

    task automatic build_frame(input int p, input int len);
        logic [63:0] header;
        logic [63:0] rnd;
        beat_t       b;
        header = take_bits(`DATA_WIDTH);
        b.data = header;
        b.keep = '1;
        b.last = (len == 1);
        b.dest = '0;
        send_mem[p][send_len[p]] = b;
        send_len[p]++;
        for (int i = 1; i < len; i++) begin
            rnd    = take_bits(`STRB_WIDTH);
            b.data = take_bits(`DATA_WIDTH);
            b.keep = rnd[`STRB_WIDTH-1:0];
            b.last = (i == len - 1);
            send_mem[p][send_len[p]] = b;
            send_len[p]++;
            exp_mem[p][exp_wr[p]] = expected_beat(header, b);
            exp_wr[p]++;
        end
    endtask

    // Runs until every beat up to send_end is sent and exp_end beats came out
    task automatic drive_phase(input bit random_ready);
        logic [63:0] rnd;
        bit          busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = 1'b0;
            for (int p = 0; p < `PORT_COUNT; p++) begin
                if (s_axis_tvalid[p] && s_axis_tready[p]) begin
                    send_pos[p]++;
                end else if (s_axis_tvalid[p]) begin
                    stall_seen[p] = 1'b1;
                end
                if (!(s_axis_tvalid[p] && !s_axis_tready[p])) begin // Stalled beat stays put
                    rnd = take_bits(2);
                    if (send_pos[p] < send_end[p] && rnd[1:0] != 2'b00) begin
                        s_axis_tdata[p*`DATA_WIDTH +: `DATA_WIDTH] <= send_mem[p][send_pos[p]].data;
                        s_axis_tkeep[p*`STRB_WIDTH +: `STRB_WIDTH] <= send_mem[p][send_pos[p]].keep;
                        s_axis_tlast[p]  <= send_mem[p][send_pos[p]].last;
                        s_axis_tvalid[p] <= 1'b1;
                    end else begin
                        s_axis_tvalid[p] <= 1'b0;
                    end
                end
                if (random_ready) begin
                    rnd = take_bits(2);
                    m_axis_tready[p] <= (rnd[1:0] == 2'b00); // Slow drain fills the FIFO
                end else begin
                    m_axis_tready[p] <= 1'b1;
                end
                if (send_pos[p] < send_end[p] || exp_rd[p] < exp_end[p]) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk) begin : compare_outputs
        beat_t got;
        beat_t want;
        if (!rst) begin
            for (int p = 0; p < `PORT_COUNT; p++) begin
                if (m_axis_tvalid[p] && m_axis_tready[p]) begin
                    got.data = m_axis_tdata[p*`DATA_WIDTH +: `DATA_WIDTH];
                    got.keep = m_axis_tkeep[p*`STRB_WIDTH +: `STRB_WIDTH];
                    got.last = m_axis_tlast[p];
                    got.dest = m_axis_tdest[p*`ID_TAG_WIDTH +: `ID_TAG_WIDTH];
                    assert (m_axis_tuser[p*`PORT_WIDTH +: `PORT_WIDTH] == `FIRST_PORT + p)
                    else begin
                        $display("[ERROR] %0t m_axis_tuser[%0d] got %0d expected %0d", $time, p,
                                 m_axis_tuser[p*`PORT_WIDTH +: `PORT_WIDTH], `FIRST_PORT + p);
                        check_errors++;
                    end
                    assert (exp_rd[p] < exp_wr[p]) else begin
                        $display("Port %0d delivered a beat when none was expected", p);
                        check_errors++;
                    end
                    if (exp_rd[p] < exp_wr[p]) begin
                        want = exp_mem[p][exp_rd[p]];
                        assert (got.data == want.data) else begin
                            $display("[ERROR] %0t m_axis_tdata[%0d] got %h expected %h",
                                     $time, p, got.data, want.data);
                            check_errors++;
                        end
                        assert (got.keep == want.keep) else begin
                            $display("[ERROR] %0t m_axis_tkeep[%0d] got %h expected %h",
                                     $time, p, got.keep, want.keep);
                            check_errors++;
                        end
                        assert (got.last == want.last) else begin
                            $display("[ERROR] %0t m_axis_tlast[%0d] got %b expected %b",
                                     $time, p, got.last, want.last);
                            check_errors++;
                        end
                        assert (got.dest == want.dest) else begin
                            $display("[ERROR] %0t m_axis_tdest[%0d] got %h expected %h",
                                     $time, p, got.dest, want.dest);
                            check_errors++;
                        end
                        beats_checked++;
                        exp_rd[p] <= exp_rd[p] + 1;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watch_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        logic [63:0] rnd;
        int          len;
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        s_axis_tuser  = '0;
        m_axis_tready = '1;
        lfsr          = SEED;

        for (int p = 0; p < `PORT_COUNT; p++) begin
            for (int f = 0; f < 12; f++) begin
                rnd = take_bits(3);
                if (f == 4) begin
                    len = 1; // Header only between two normal frames
                end else if (f == 3 || f == 5) begin
                    len = 2 + int'(rnd[2:0]) % 5;
                end else begin
                    len = 1 + int'(rnd[2:0]) % 6;
                end
                build_frame(p, len);
            end
            phase1_send[p] = send_len[p];
            phase1_exp[p]  = exp_wr[p];
            for (int f = 0; f < 6; f++) begin
                rnd = take_bits(4);
                build_frame(p, 20 + int'(rnd[3:0])); // Longer than the FIFO
            end
        end
        watch_cycles = (send_len[0] + send_len[1]) * 40;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (m_axis_tvalid == '0) else begin
            $display("[ERROR] %0t m_axis_tvalid got %b expected %b", $time, m_axis_tvalid, 2'b00);
            flow_errors++;
        end
        assert (s_axis_tready == '1) else begin
            $display("[ERROR] %0t s_axis_tready got %b expected %b", $time, s_axis_tready, 2'b11);
            flow_errors++;
        end

        send_end = phase1_send;
        exp_end  = phase1_exp;
        drive_phase(1'b0);

        send_end = send_len;
        exp_end  = exp_wr;
        drive_phase(1'b1);
        for (int p = 0; p < `PORT_COUNT; p++) begin
            assert (stall_seen[p]) else begin
                $display("Port %0d never dropped s_axis_tready under back-pressure", p);
                flow_errors++;
            end
        end

        // Idle tail where any extra output beat is caught by the comparator
        @(posedge clk);
        m_axis_tready <= '1;
        repeat (20) @(posedge clk);

        $display("Checked %0d beats, compare errors %0d, flow errors %0d",
                 beats_checked, check_errors, flow_errors);
        if (check_errors + flow_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== loopback_msg_assert.sv ====
`timescale 1ns/1ns
`include "loopback_msg_macros.svh"

module loopback_msg_assert (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`PORT_COUNT*`DATA_WIDTH-1:0]   m_axis_tdata,
    input  logic [`PORT_COUNT*`STRB_WIDTH-1:0]   m_axis_tkeep,
    input  logic [`PORT_COUNT-1:0]               m_axis_tvalid,
    input  logic [`PORT_COUNT-1:0]               m_axis_tlast,
    input  logic [`PORT_COUNT*`ID_TAG_WIDTH-1:0] m_axis_tdest,
    input  logic [`PORT_COUNT*`PORT_WIDTH-1:0]   m_axis_tuser,
    input  logic [`PORT_COUNT-1:0]               m_axis_tready
);

    genvar i;

    generate
        for (i = 0; i < `PORT_COUNT; i++) begin : g_port

            // A stalled output beat must not change
            hold_stable: assert property (@(posedge clk) disable iff (rst)
                m_axis_tvalid[i] && !m_axis_tready[i] |=>
                    m_axis_tvalid[i] &&
                    $stable(m_axis_tdata[i*`DATA_WIDTH +: `DATA_WIDTH]) &&
                    $stable(m_axis_tkeep[i*`STRB_WIDTH +: `STRB_WIDTH]) &&
                    $stable(m_axis_tlast[i]) &&
                    $stable(m_axis_tdest[i*`ID_TAG_WIDTH +: `ID_TAG_WIDTH]))
                else $error("Port %0d output beat changed while stalled", i);

            quiet_after_reset: assert property (@(posedge clk)
                $past(rst) |-> !m_axis_tvalid[i])
                else $error("Port %0d m_axis_tvalid high during or right after reset", i);

            fixed_port_num: assert property (@(posedge clk)
                m_axis_tuser[i*`PORT_WIDTH +: `PORT_WIDTH] == `FIRST_PORT + i)
                else $error("Port %0d m_axis_tuser differs from its port number", i);

        end
    endgenerate

endmodule

bind loopback_msg_fifo loopback_msg_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdest  (m_axis_tdest),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tready (m_axis_tready)
);

// ==== loopback_msg_fifo.sv ====
`timescale 1ns/1ns
`include "loopback_msg_macros.svh"

module loopback_msg_fifo (
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic [`PORT_COUNT*`DATA_WIDTH-1:0]    s_axis_tdata,
    input  logic [`PORT_COUNT*`STRB_WIDTH-1:0]    s_axis_tkeep,
    input  logic [`PORT_COUNT-1:0]                s_axis_tvalid,
    input  logic [`PORT_COUNT-1:0]                s_axis_tlast,
    input  logic [`PORT_COUNT*`ID_TAG_WIDTH-1:0]  s_axis_tuser, // Not used by the loopback
    output logic [`PORT_COUNT-1:0]                s_axis_tready,

    output logic [`PORT_COUNT*`DATA_WIDTH-1:0]    m_axis_tdata,
    output logic [`PORT_COUNT*`STRB_WIDTH-1:0]    m_axis_tkeep,
    output logic [`PORT_COUNT-1:0]                m_axis_tvalid,
    output logic [`PORT_COUNT-1:0]                m_axis_tlast,
    output logic [`PORT_COUNT*`ID_TAG_WIDTH-1:0]  m_axis_tdest,
    output logic [`PORT_COUNT*`PORT_WIDTH-1:0]    m_axis_tuser,
    input  logic [`PORT_COUNT-1:0]                m_axis_tready
);

    genvar i;

    generate
        for (i = 0; i < `PORT_COUNT; i++) begin : g_port

            axis_msg_if lane ();

            // Each lane reports its own fixed port number
            assign m_axis_tuser[i*`PORT_WIDTH +: `PORT_WIDTH] =
                loopback_msg_pkg::port_num_t'(`FIRST_PORT + i);

            header_remover u_remover (
                .clk           (clk),
                .rst           (rst),

                .s_axis_tdata  (s_axis_tdata[i*`DATA_WIDTH +: `DATA_WIDTH]),
                .s_axis_tkeep  (s_axis_tkeep[i*`STRB_WIDTH +: `STRB_WIDTH]),
                .s_axis_tvalid (s_axis_tvalid[i]),
                .s_axis_tlast  (s_axis_tlast[i]),
                .s_axis_tready (s_axis_tready[i]),

                .m             (lane.src)
            );

            axis_fifo #(
                .DEPTH         (`FIFO_DEPTH)
            ) u_fifo (
                .clk           (clk),
                .rst           (rst),

                .s             (lane.dst),

                .m_axis_tdata  (m_axis_tdata[i*`DATA_WIDTH +: `DATA_WIDTH]),
                .m_axis_tkeep  (m_axis_tkeep[i*`STRB_WIDTH +: `STRB_WIDTH]),
                .m_axis_tvalid (m_axis_tvalid[i]),
                .m_axis_tlast  (m_axis_tlast[i]),
                .m_axis_tdest  (m_axis_tdest[i*`ID_TAG_WIDTH +: `ID_TAG_WIDTH]),
                .m_axis_tready (m_axis_tready[i])
            );

        end
    endgenerate

endmodule

// ==== axis_fifo.sv ====
`timescale 1ns/1ns
`include "loopback_msg_macros.svh"

module axis_fifo #(
    parameter int DEPTH = `FIFO_DEPTH // Must be a power of two
) (
    input  logic                      clk,
    input  logic                      rst,

    axis_msg_if.dst                   s,

    output logic [`DATA_WIDTH-1:0]    m_axis_tdata,
    output logic [`STRB_WIDTH-1:0]    m_axis_tkeep,
    output logic                      m_axis_tvalid,
    output logic                      m_axis_tlast,
    output loopback_msg_pkg::id_tag_t m_axis_tdest,
    input  logic                      m_axis_tready
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH+1)'(DEPTH);

    logic [`DATA_WIDTH-1:0]    data_mem [DEPTH];
    logic [`STRB_WIDTH-1:0]    keep_mem [DEPTH];
    logic                      last_mem [DEPTH];
    loopback_msg_pkg::id_tag_t dest_mem [DEPTH];

    logic [ADDR_WIDTH-1:0]     wr_ptr;
    logic [ADDR_WIDTH-1:0]     rd_ptr;
    logic [ADDR_WIDTH:0]       count;
    logic                      full;
    logic                      empty;
    logic                      wr_en;
    logic                      rd_en;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);

    assign s.tready      = !full;
    assign m_axis_tvalid = !empty;

    assign wr_en = s.tvalid && !full;
    assign rd_en = m_axis_tready && !empty;

    // First word falls through so the head entry is always on the output
    assign m_axis_tdata = data_mem[rd_ptr];
    assign m_axis_tkeep = keep_mem[rd_ptr];
    assign m_axis_tlast = last_mem[rd_ptr];
    assign m_axis_tdest = dest_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= s.tdata;
            keep_mem[wr_ptr] <= s.tkeep;
            last_mem[wr_ptr] <= s.tlast;
            dest_mem[wr_ptr] <= s.tdest;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or read and write together
            endcase
        end
    end

endmodule

// ==== header_remover.sv ====
`timescale 1ns/1ns
`include "loopback_msg_macros.svh"

module header_remover (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [`DATA_WIDTH-1:0] s_axis_tdata,
    input  logic [`STRB_WIDTH-1:0] s_axis_tkeep,
    input  logic                   s_axis_tvalid,
    input  logic                   s_axis_tlast,
    output logic                   s_axis_tready,

    axis_msg_if.src                m
);

    loopback_msg_pkg::hdr_state_t state;
    loopback_msg_pkg::hdr_state_t state_next;
    loopback_msg_pkg::id_tag_t    tag;
    logic                         s_xfer;

    assign s_xfer = s_axis_tvalid && s_axis_tready;

    // Payload beats go straight through while only the handshake is gated
    assign m.tdata = s_axis_tdata;
    assign m.tkeep = s_axis_tkeep;
    assign m.tlast = s_axis_tlast;
    assign m.tdest = tag; // Held for the whole frame

    always_comb begin
        case (state)
            loopback_msg_pkg::HDR_PAYLOAD: begin
                m.tvalid      = s_axis_tvalid;
                s_axis_tready = m.tready; // Stall with the FIFO
            end
            default: begin
                m.tvalid      = 1'b0;    // Header never reaches the FIFO
                s_axis_tready = 1'b1;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            loopback_msg_pkg::HDR_WAIT: begin
                // A header-only frame is dropped and we wait for the next header
                if (s_xfer && !s_axis_tlast) begin
                    state_next = loopback_msg_pkg::HDR_PAYLOAD;
                end
            end
            loopback_msg_pkg::HDR_PAYLOAD: begin
                if (s_xfer && s_axis_tlast) begin
                    state_next = loopback_msg_pkg::HDR_WAIT;
                end
            end
            default: begin
                state_next = loopback_msg_pkg::HDR_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= loopback_msg_pkg::HDR_WAIT;
        end else begin
            state <= state_next;
        end
    end

    // Low bits of the header carry the destination tag
    always_ff @(posedge clk) begin
        if (state == loopback_msg_pkg::HDR_WAIT && s_xfer) begin
            tag <= s_axis_tdata[`ID_TAG_WIDTH-1:0];
        end
    end

endmodule

// ==== axis_msg_if.sv ====
`timescale 1ns/1ns
`include "loopback_msg_macros.svh"

interface axis_msg_if;

    logic [`DATA_WIDTH-1:0]    tdata;
    logic [`STRB_WIDTH-1:0]    tkeep;
    logic                      tvalid;
    logic                      tlast;
    loopback_msg_pkg::id_tag_t tdest;
    logic                      tready;

    // Header remover side
    modport src (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tdest,
        input  tready
    );

    // FIFO side
    modport dst (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        input  tdest,
        output tready
    );

endinterface

// ==== loopback_msg_pkg.sv ====
`include "loopback_msg_macros.svh"

package loopback_msg_pkg;

    // Header remover FSM
    typedef enum logic {
        HDR_WAIT    = 1'b0, // Next beat is the destination header
        HDR_PAYLOAD = 1'b1  // Forwarding payload until tlast
    } hdr_state_t;

    // Destination tag taken from the low bits of the header beat
    typedef logic [`ID_TAG_WIDTH-1:0] id_tag_t;

    // Fixed number stamped on each output lane
    typedef logic [`PORT_WIDTH-1:0] port_num_t;

endpackage

// ==== loopback_msg_macros.svh ====
`ifndef LOOPBACK_MSG_MACROS_SVH
`define LOOPBACK_MSG_MACROS_SVH

// Stream beat and keep widths
`define DATA_WIDTH    64
`define STRB_WIDTH    (`DATA_WIDTH/8)

// Destination tag is slot bits plus core index
`define CORE_WIDTH    4
`define ID_TAG_WIDTH  (5+`CORE_WIDTH)

// Loopback port numbering
`define PORT_WIDTH    2
`define PORT_COUNT    2
`define FIRST_PORT    2

// Beats of buffering per port, power of two
`define FIFO_DEPTH    16

`endif
